//--- sim/frames_input.txt
// test in_color bg_color x0 y0 x1 y1 lower upper exp_valid exp_x exp_y
// hex fields, colors RGB565, bounds on Cr, rectangle corners inclusive
1 F800 0000 4 3 7 5 C8 FF 1 5 4
2 F800 0000 4 3 7 5 F0 FF 0 0 0
3 F800 F800 0 0 F B C8 FF 1 7 5
4 F801 F800 A 6 D 9 C8 EB 1 B 7
5 F800 F801 1 A 2 B EC FF 1 1 A
6 001F 0000 2 1 9 2 64 78 1 5 1

//--- verilog.f
hdl/camera_pkg.sv
hdl/tracking_pkg.sv
hdl/align_delay.sv
hdl/serial_divider.sv
hdl/pixel_reconstruct.sv
hdl/chroma_threshold.sv
hdl/centroid_tracker.sv
hdl/baton_top.sv
sim/baton_props.sv
sim/tb_baton.sv

//--- Bender.yml
package:
  name: baton_tracker

sources:
  - hdl/camera_pkg.sv
  - hdl/tracking_pkg.sv
  - hdl/align_delay.sv
  - hdl/serial_divider.sv
  - hdl/pixel_reconstruct.sv
  - hdl/chroma_threshold.sv
  - hdl/centroid_tracker.sv
  - hdl/baton_top.sv
  - target: simulation
    files:
      - sim/baton_props.sv
      - sim/tb_baton.sv

//--- sim/tb_baton.sv
module tb_baton;

   localparam int FRAME_W   = 16;
   localparam int FRAME_H   = 12;
   // columns per line of the frame description file
   localparam int FIELDS    = 12;
   localparam int MAX_TESTS = 32;
   // cycles allowed from the end of a frame to its centroid
   localparam int RESULT_TIMEOUT = 2000;
   // longest ready stall, far shorter than one frame
   localparam int MAX_STALL = 200;

   logic                  clk_camera;
   logic                  recent_reset;
   camera_pkg::byte_t     camera_d_i;
   logic                  camera_pclk_i;
   logic                  camera_hsync_i;
   logic                  camera_vsync_i;
   logic [7:0]            lower_bound_i;
   logic [7:0]            upper_bound_i;
   logic                  centroid_ready_i;
   logic                  centroid_valid_o;
   tracking_pkg::hcount_t centroid_x_o;
   tracking_pkg::vcount_t centroid_y_o;

   // frame descriptions, unread entries stay unknown
   logic [31:0] vectors [MAX_TESTS*FIELDS];
   int          test_errors;

   baton_top #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H)
   ) dut0 (
      .clk_camera      (clk_camera),
      .recent_reset    (recent_reset),
      .camera_d_i      (camera_d_i),
      .camera_pclk_i   (camera_pclk_i),
      .camera_hsync_i  (camera_hsync_i),
      .camera_vsync_i  (camera_vsync_i),
      .lower_bound_i   (lower_bound_i),
      .upper_bound_i   (upper_bound_i),
      .centroid_ready_i(centroid_ready_i),
      .centroid_valid_o(centroid_valid_o),
      .centroid_x_o    (centroid_x_o),
      .centroid_y_o    (centroid_y_o)
   );

   always #5 clk_camera = ~clk_camera;

   // one bus byte, pclk low for two cycles then high for two
   task automatic send_byte(input logic [7:0] value);
      @(posedge clk_camera);
      camera_d_i    <= value;
      camera_pclk_i <= 1'b0;
      @(posedge clk_camera);
      @(posedge clk_camera);
      camera_pclk_i <= 1'b1;
      @(posedge clk_camera);
   endtask

   // a full frame with one rectangle of in_color on bg_color
   task automatic send_frame(input logic [15:0] in_color, input logic [15:0] bg_color,
                             input int x0, input int y0, input int x1, input int y1);
      logic [15:0] color;
      @(posedge clk_camera);
      camera_vsync_i <= 1'b1;
      repeat (6) @(posedge clk_camera);
      camera_vsync_i <= 1'b0;
      repeat (6) @(posedge clk_camera);
      for (int y = 0; y < FRAME_H; y++) begin
         @(posedge clk_camera);
         camera_hsync_i <= 1'b1;
         for (int x = 0; x < FRAME_W; x++) begin
            color = (x >= x0 && x <= x1 && y >= y0 && y <= y1) ? in_color : bg_color;
            // high byte goes first on the bus
            send_byte(color[15:8]);
            send_byte(color[7:0]);
         end
         @(posedge clk_camera);
         camera_hsync_i <= 1'b0;
         camera_pclk_i  <= 1'b0;
         // random horizontal blanking
         repeat ($urandom_range(4, 19)) @(posedge clk_camera);
      end
      // vertical blanking covers the pipeline and both dividers
      repeat (64) @(posedge clk_camera);
   endtask

   // wait for the centroid, stall it, then take it once
   task automatic collect_result(input string name, input tracking_pkg::hcount_t exp_x,
                                 input tracking_pkg::vcount_t exp_y, output bit timed_out);
      int                    waited;
      int                    stall;
      tracking_pkg::hcount_t held_x;
      tracking_pkg::vcount_t held_y;
      waited    = 0;
      timed_out = 1'b0;
      @(negedge clk_camera);
      while (!centroid_valid_o && waited < RESULT_TIMEOUT) begin
         @(negedge clk_camera);
         waited++;
      end
      assert (centroid_valid_o) else begin
         $display("%s: no centroid result within %0d cycles", name, RESULT_TIMEOUT);
         test_errors++;
         timed_out = 1'b1;
      end
      if (!timed_out) begin
         held_x = centroid_x_o;
         held_y = centroid_y_o;
         assert (held_x == exp_x && held_y == exp_y) else begin
            $display("Fail %s: expected (%0d, %0d), actual (%0d, %0d)",
                     name, exp_x, exp_y, held_x, held_y);
            test_errors++;
         end
         stall = $urandom_range(0, MAX_STALL);
         for (int i = 0; i < stall; i++) begin
            @(negedge clk_camera);
            assert (centroid_valid_o && centroid_x_o == held_x && centroid_y_o == held_y)
            else begin
               $display("%s: result changed while ready was low", name);
               test_errors++;
            end
         end
         // ready for a single cycle
         @(posedge clk_camera);
         centroid_ready_i <= 1'b1;
         @(posedge clk_camera);
         centroid_ready_i <= 1'b0;
         @(negedge clk_camera);
         assert (!centroid_valid_o) else begin
            $display("%s: valid still high after the transfer", name);
            test_errors++;
         end
      end
   endtask

   // empty frames leave the output idle
   task automatic check_no_result(input string name);
      @(negedge clk_camera);
      assert (!centroid_valid_o) else begin
         $display("%s: centroid result for a frame with no in-band pixel", name);
         test_errors++;
      end
   endtask

   initial begin
      logic [31:0] row [FIELDS];
      int          num_tests;
      int          errors;
      int          passed;
      int          failed;
      int          prop_failures;
      bit          timed_out;
      string       name;
      clk_camera       = 1'b0;
      recent_reset     = 1'b1;
      camera_d_i       = '0;
      camera_pclk_i    = 1'b0;
      camera_hsync_i   = 1'b0;
      camera_vsync_i   = 1'b0;
      lower_bound_i    = '0;
      upper_bound_i    = '0;
      centroid_ready_i = 1'b0;
      errors           = 0;
      passed           = 0;
      failed           = 0;
      timed_out        = 1'b0;
      void'($urandom(32'h2aa0_5372));
      $readmemh("sim/frames_input.txt", vectors);
      num_tests = 0;
      while (num_tests < MAX_TESTS && !$isunknown(vectors[num_tests*FIELDS])) begin
         num_tests++;
      end
      repeat (10) @(posedge clk_camera);
      recent_reset <= 1'b0;
      repeat (4) @(posedge clk_camera);
      for (int t = 0; t < num_tests && !timed_out; t++) begin
         for (int f = 0; f < FIELDS; f++) begin
            row[f] = vectors[t*FIELDS+f];
         end
         name        = $sformatf("frame_%0d", row[0]);
         test_errors = 0;
         // band bounds stay put for the whole frame
         @(posedge clk_camera);
         lower_bound_i <= row[7][7:0];
         upper_bound_i <= row[8][7:0];
         send_frame(row[1][15:0], row[2][15:0], row[3], row[4], row[5], row[6]);
         if (row[9] != 0) begin
            collect_result(name, row[10][10:0], row[11][9:0], timed_out);
         end else begin
            check_no_result(name);
         end
         errors += test_errors;
         if (test_errors == 0) begin
            passed++;
            $display("%s pass", name);
         end else begin
            failed++;
         end
      end
      prop_failures = dut0.centroid_tracker0.props0.failures;
      errors += prop_failures;
      $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
               passed + failed, passed, failed, prop_failures);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- sim/baton_props.sv
module baton_props #(
   parameter int FRAME_W = tracking_pkg::DEF_FRAME_W
) (
   input logic                  clk_camera,
   input logic                  recent_reset,
   input logic                  valid_i,
   input logic                  ready_i,
   input tracking_pkg::hcount_t x_i,
   input tracking_pkg::vcount_t y_i
);

   // count of failed assertions
   int failures = 0;

   // result register comes out of reset empty
   reset_clears_valid: assert property (
      @(posedge clk_camera) recent_reset |=> !valid_i
   ) else begin
      $error("centroid valid high right after reset");
      failures++;
   end

   // a pending result holds until ready takes it
   result_held: assert property (
      @(posedge clk_camera) disable iff (recent_reset)
      (valid_i && !ready_i) |=> (valid_i && $stable(x_i) && $stable(y_i))
   ) else begin
      $error("centroid result changed while ready was low");
      failures++;
   end

   // the mean column lies inside the window
   x_in_window: assert property (
      @(posedge clk_camera) disable iff (recent_reset)
      valid_i |-> (x_i < FRAME_W)
   ) else begin
      $error("centroid x outside the frame");
      failures++;
   end

endmodule

bind centroid_tracker baton_props #(
   .FRAME_W(FRAME_W)
) props0 (
   .clk_camera  (clk_camera),
   .recent_reset(recent_reset),
   .valid_i     (centroid_valid_o),
   .ready_i     (centroid_ready_i),
   .x_i         (centroid_x_o),
   .y_i         (centroid_y_o)
);

//--- hdl/baton_top.sv
module baton_top #(
   parameter int FRAME_W = tracking_pkg::DEF_FRAME_W,
   parameter int FRAME_H = tracking_pkg::DEF_FRAME_H
) (
   input  logic                  clk_camera,
   input  logic                  recent_reset,
   input  camera_pkg::byte_t     camera_d_i,
   input  logic                  camera_pclk_i,
   input  logic                  camera_hsync_i,
   input  logic                  camera_vsync_i,
   input  logic [7:0]            lower_bound_i,
   input  logic [7:0]            upper_bound_i,
   input  logic                  centroid_ready_i,
   output logic                  centroid_valid_o,
   output tracking_pkg::hcount_t centroid_x_o,
   output tracking_pkg::vcount_t centroid_y_o
);

   logic                  pixel_valid;
   camera_pkg::pixel_t    pixel;
   tracking_pkg::hcount_t hcount, hcount_aligned;
   tracking_pkg::vcount_t vcount, vcount_aligned;
   logic                  frame_end, frame_end_aligned;
   logic                  mask_valid, mask;

   // camera bytes to pixels
   pixel_reconstruct #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H)
   ) pixel_reconstruct0 (
      .clk_camera    (clk_camera),
      .recent_reset  (recent_reset),
      .camera_d_i    (camera_d_i),
      .camera_pclk_i (camera_pclk_i),
      .camera_hsync_i(camera_hsync_i),
      .camera_vsync_i(camera_vsync_i),
      .pixel_valid_o (pixel_valid),
      .pixel_o       (pixel),
      .hcount_o      (hcount),
      .vcount_o      (vcount),
      .frame_end_o   (frame_end)
   );

   // Cr band mask
   chroma_threshold chroma_threshold0 (
      .clk_camera   (clk_camera),
      .recent_reset (recent_reset),
      .pixel_valid_i(pixel_valid),
      .pixel_i      (pixel),
      .lower_bound_i(lower_bound_i),
      .upper_bound_i(upper_bound_i),
      .mask_valid_o (mask_valid),
      .mask_o       (mask)
   );

   // coordinates and frame end follow the chroma pipeline
   align_delay #(
      .DEPTH    (tracking_pkg::CHROMA_LATENCY),
      .payload_t(tracking_pkg::hcount_t)
   ) hcount_delay (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .data_i      (hcount),
      .data_o      (hcount_aligned)
   );

   align_delay #(
      .DEPTH    (tracking_pkg::CHROMA_LATENCY),
      .payload_t(tracking_pkg::vcount_t)
   ) vcount_delay (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .data_i      (vcount),
      .data_o      (vcount_aligned)
   );

   align_delay #(
      .DEPTH    (tracking_pkg::CHROMA_LATENCY),
      .payload_t(logic)
   ) frame_end_delay (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .data_i      (frame_end),
      .data_o      (frame_end_aligned)
   );

   // per-frame centroid with valid/ready result
   centroid_tracker #(
      .FRAME_W(FRAME_W),
      .FRAME_H(FRAME_H)
   ) centroid_tracker0 (
      .clk_camera      (clk_camera),
      .recent_reset    (recent_reset),
      .mask_valid_i    (mask_valid),
      .mask_i          (mask),
      .hcount_i        (hcount_aligned),
      .vcount_i        (vcount_aligned),
      .frame_end_i     (frame_end_aligned),
      .centroid_ready_i(centroid_ready_i),
      .centroid_valid_o(centroid_valid_o),
      .centroid_x_o    (centroid_x_o),
      .centroid_y_o    (centroid_y_o)
   );

endmodule

//--- hdl/centroid_tracker.sv
module centroid_tracker #(
   parameter int FRAME_W = tracking_pkg::DEF_FRAME_W,
   parameter int FRAME_H = tracking_pkg::DEF_FRAME_H
) (
   input  logic                  clk_camera,
   input  logic                  recent_reset,
   input  logic                  mask_valid_i,
   input  logic                  mask_i,
   input  tracking_pkg::hcount_t hcount_i,
   input  tracking_pkg::vcount_t vcount_i,
   input  logic                  frame_end_i,
   input  logic                  centroid_ready_i,
   output logic                  centroid_valid_o,
   output tracking_pkg::hcount_t centroid_x_o,
   output tracking_pkg::vcount_t centroid_y_o
);

   localparam int SUM_W    = tracking_pkg::SUM_W;
   localparam int COUNT_W  = tracking_pkg::COUNT_W;
   localparam int HCOUNT_W = tracking_pkg::HCOUNT_W;
   localparam int VCOUNT_W = tracking_pkg::VCOUNT_W;

   logic [SUM_W-1:0]   sum_x, sum_y, sum_x_next, sum_y_next;
   logic [COUNT_W-1:0] count, count_next;
   logic               hit, frame_done, div_start, load_result;
   logic [SUM_W-1:0]   quot_x, quot_y;
   logic               done_x, done_y;

   // in-band pixel inside the camera window
   assign hit = mask_valid_i && mask_i && (hcount_i < FRAME_W) && (vcount_i < FRAME_H);

   // totals including the current pixel
   always_comb begin
      sum_x_next = sum_x;
      sum_y_next = sum_y;
      count_next = count;
      if (hit) begin
         sum_x_next = sum_x + SUM_W'(hcount_i);
         sum_y_next = sum_y + SUM_W'(vcount_i);
         count_next = count + 1'b1;
      end
   end

   assign frame_done = mask_valid_i && frame_end_i;
   // empty frames give no result
   assign div_start  = frame_done && (count_next != '0);

   always_ff @(posedge clk_camera) begin
      if (recent_reset || frame_done) begin
         sum_x <= '0;
         sum_y <= '0;
         count <= '0;
      end else begin
         sum_x <= sum_x_next;
         sum_y <= sum_y_next;
         count <= count_next;
      end
   end

   // the dividers capture the frame totals when started
   serial_divider #(
      .DIVIDEND_W(SUM_W)
   ) div_x (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .start_i     (div_start),
      .dividend_i  (sum_x_next),
      .divisor_i   (count_next),
      .quotient_o  (quot_x),
      .done_o      (done_x)
   );

   serial_divider #(
      .DIVIDEND_W(SUM_W)
   ) div_y (
      .clk_camera  (clk_camera),
      .recent_reset(recent_reset),
      .start_i     (div_start),
      .dividend_i  (sum_y_next),
      .divisor_i   (count_next),
      .quotient_o  (quot_y),
      .done_o      (done_y)
   );

   // a new result only loads once the previous one has been taken
   assign load_result = done_x && done_y && !centroid_valid_o;

   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         centroid_valid_o <= 1'b0;
      end else if (load_result) begin
         centroid_valid_o <= 1'b1;
      end else if (centroid_ready_i) begin
         centroid_valid_o <= 1'b0;
      end
   end

   // means are bounded by the window, the low bits hold them
   always_ff @(posedge clk_camera) begin
      if (load_result) begin
         centroid_x_o <= quot_x[HCOUNT_W-1:0];
         centroid_y_o <= quot_y[VCOUNT_W-1:0];
      end
   end

endmodule

//--- hdl/chroma_threshold.sv
module chroma_threshold (
   input  logic               clk_camera,
   input  logic               recent_reset,
   input  logic               pixel_valid_i,
   input  camera_pkg::pixel_t pixel_i,
   input  logic [7:0]         lower_bound_i,
   input  logic [7:0]         upper_bound_i,
   output logic               mask_valid_o,
   output logic               mask_o
);

   localparam int CHAN_W = camera_pkg::CHAN_W;
   // 8 bit channel times 8 bit coefficient
   localparam int PROD_W = 16;
   // room for the sign and the subtraction
   localparam int ACC_W  = PROD_W + 2;

   logic [camera_pkg::RED_W-1:0]   red;
   logic [camera_pkg::GREEN_W-1:0] green;
   logic [camera_pkg::BLUE_W-1:0]  blue;
   logic [CHAN_W-1:0]              red8, green8, blue8;
   logic [PROD_W-1:0]              prod_r, prod_g, prod_b;
   logic                           stage1_valid;
   logic signed [ACC_W-1:0]        cr_sum, cr_floor, cr_off;
   logic [7:0]                     cr;

   // split RGB565 into its fields
   assign red   = pixel_i[camera_pkg::PIXEL_W-1 -: camera_pkg::RED_W];
   assign green = pixel_i[camera_pkg::BLUE_W +: camera_pkg::GREEN_W];
   assign blue  = pixel_i[camera_pkg::BLUE_W-1:0];

   // expand to 8 bits, low bits zero
   assign red8   = {red, {(CHAN_W - camera_pkg::RED_W){1'b0}}};
   assign green8 = {green, {(CHAN_W - camera_pkg::GREEN_W){1'b0}}};
   assign blue8  = {blue, {(CHAN_W - camera_pkg::BLUE_W){1'b0}}};

   // stage one, weighted products
   always_ff @(posedge clk_camera) begin
      if (pixel_valid_i) begin
         prod_r <= red8 * tracking_pkg::CR_KR;
         prod_g <= green8 * tracking_pkg::CR_KG;
         prod_b <= blue8 * tracking_pkg::CR_KB;
      end
   end

   // stage two arithmetic
   always_comb begin
      cr_sum   = $signed({2'b00, prod_r}) - $signed({2'b00, prod_g}) -
                 $signed({2'b00, prod_b});
      // arithmetic shift gives the floor for negative sums too
      cr_floor = cr_sum >>> 8;
      cr_off   = cr_floor + $signed({{(ACC_W - 8){1'b0}}, tracking_pkg::CR_OFFSET});
      // clamp into the 8 bit range
      if (cr_off < 0) begin
         cr = '0;
      end else if (cr_off > 255) begin
         cr = '1;
      end else begin
         cr = cr_off[7:0];
      end
   end

   // stage two register, inclusive band compare
   always_ff @(posedge clk_camera) begin
      if (stage1_valid) begin
         mask_o <= (cr >= lower_bound_i) && (cr <= upper_bound_i);
      end
   end

   // valid follows the data two cycles behind pixel valid
   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         stage1_valid <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         stage1_valid <= pixel_valid_i;
         mask_valid_o <= stage1_valid;
      end
   end

endmodule

//--- hdl/pixel_reconstruct.sv
module pixel_reconstruct #(
   parameter int FRAME_W = tracking_pkg::DEF_FRAME_W,
   parameter int FRAME_H = tracking_pkg::DEF_FRAME_H
) (
   input  logic                  clk_camera,
   input  logic                  recent_reset,
   input  camera_pkg::byte_t     camera_d_i,
   input  logic                  camera_pclk_i,
   input  logic                  camera_hsync_i,
   input  logic                  camera_vsync_i,
   output logic                  pixel_valid_o,
   output camera_pkg::pixel_t    pixel_o,
   output tracking_pkg::hcount_t hcount_o,
   output tracking_pkg::vcount_t vcount_o,
   output logic                  frame_end_o
);

   camera_pkg::byte_t     d_meta, d_sync;
   logic                  pclk_meta, pclk_sync, pclk_prev;
   logic                  hsync_meta, hsync_sync, hsync_prev;
   logic                  vsync_meta, vsync_sync;
   logic                  pclk_rise, hsync_fall, take_byte;
   logic                  low_phase;
   camera_pkg::byte_t     high_byte;
   tracking_pkg::hcount_t hcount;
   tracking_pkg::vcount_t vcount;

   // two flop synchronizers on every camera input
   always_ff @(posedge clk_camera) begin
      d_meta     <= camera_d_i;
      d_sync     <= d_meta;
      pclk_meta  <= camera_pclk_i;
      pclk_sync  <= pclk_meta;
      hsync_meta <= camera_hsync_i;
      hsync_sync <= hsync_meta;
      vsync_meta <= camera_vsync_i;
      vsync_sync <= vsync_meta;
   end

   // previous values for edge detection
   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         pclk_prev  <= 1'b0;
         hsync_prev <= 1'b0;
      end else begin
         pclk_prev  <= pclk_sync;
         hsync_prev <= hsync_sync;
      end
   end

   assign pclk_rise  = pclk_sync & ~pclk_prev;
   assign hsync_fall = hsync_prev & ~hsync_sync;
   // bytes only count inside the active part of a line
   assign take_byte  = pclk_rise & hsync_sync;

   // byte pairing, line and frame counters
   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         pixel_valid_o <= 1'b0;
         frame_end_o   <= 1'b0;
         low_phase     <= 1'b0;
         hcount        <= '0;
         vcount        <= '0;
      end else begin
         pixel_valid_o <= 1'b0;
         frame_end_o   <= 1'b0;
         if (hsync_fall) begin
            // end of line, next line starts again on a high byte
            hcount    <= '0;
            vcount    <= vcount + 1'b1;
            low_phase <= 1'b0;
         end else if (take_byte) begin
            if (low_phase) begin
               pixel_valid_o <= 1'b1;
               frame_end_o   <= (hcount == tracking_pkg::hcount_t'(FRAME_W - 1)) &&
                                (vcount == tracking_pkg::vcount_t'(FRAME_H - 1));
               hcount        <= hcount + 1'b1;
            end
            low_phase <= ~low_phase;
         end
         // vsync holds the row counter at the top of the frame
         if (vsync_sync) begin
            vcount <= '0;
         end
      end
   end

   // pixel payload and its coordinates
   always_ff @(posedge clk_camera) begin
      if (take_byte) begin
         if (!low_phase) begin
            high_byte <= d_sync;
         end else begin
            pixel_o  <= {high_byte, d_sync};
            hcount_o <= hcount;
            vcount_o <= vcount;
         end
      end
   end

endmodule

//--- hdl/serial_divider.sv
module serial_divider #(
   parameter int DIVIDEND_W = tracking_pkg::SUM_W
) (
   input  logic                            clk_camera,
   input  logic                            recent_reset,
   input  logic                            start_i,
   input  logic [DIVIDEND_W-1:0]           dividend_i,
   input  logic [tracking_pkg::COUNT_W-1:0] divisor_i,
   output logic [DIVIDEND_W-1:0]           quotient_o,
   output logic                            done_o
);

   localparam int DIV_W = tracking_pkg::COUNT_W;
   localparam int CNT_W = $clog2(DIVIDEND_W + 1);

   logic             busy;
   logic [CNT_W-1:0] bits_left;
   logic [DIV_W-1:0] divisor, remainder;
   logic [DIV_W:0]   partial;
   logic [DIV_W+1:0] diff;

   // bring down the next dividend bit
   assign partial = {remainder, quotient_o[DIVIDEND_W-1]};
   // top bit set means the trial subtraction went negative
   assign diff    = {1'b0, partial} - {2'b00, divisor};

   // busy state and bit counter
   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         busy      <= 1'b0;
         done_o    <= 1'b0;
         bits_left <= '0;
      end else begin
         done_o <= 1'b0;
         if (busy) begin
            bits_left <= bits_left - 1'b1;
            if (bits_left == CNT_W'(1)) begin
               busy   <= 1'b0;
               done_o <= 1'b1;
            end
         end else if (start_i) begin
            busy      <= 1'b1;
            bits_left <= CNT_W'(DIVIDEND_W);
         end
      end
   end

   // quotient_o shifts dividend bits out the top and quotient bits in the bottom
   always_ff @(posedge clk_camera) begin
      if (!busy && start_i) begin
         quotient_o <= dividend_i;
         remainder  <= '0;
         divisor    <= divisor_i;
      end else if (busy) begin
         if (!diff[DIV_W+1]) begin
            remainder  <= diff[DIV_W-1:0];
            quotient_o <= {quotient_o[DIVIDEND_W-2:0], 1'b1};
         end else begin
            // restore, keep the shifted remainder
            remainder  <= partial[DIV_W-1:0];
            quotient_o <= {quotient_o[DIVIDEND_W-2:0], 1'b0};
         end
      end
   end

endmodule

//--- hdl/align_delay.sv
module align_delay #(
   parameter int  DEPTH     = 2,
   parameter type payload_t = logic
) (
   input  logic     clk_camera,
   input  logic     recent_reset,
   input  payload_t data_i,
   output payload_t data_o
);

   // one register per cycle of delay
   payload_t stages [DEPTH];

   always_ff @(posedge clk_camera) begin
      if (recent_reset) begin
         for (int i = 0; i < DEPTH; i++) begin
            stages[i] <= '0;
         end
      end else begin
         stages[0] <= data_i;
         // every stage can hold a different item
         for (int i = 1; i < DEPTH; i++) begin
            stages[i] <= stages[i-1];
         end
      end
   end

   assign data_o = stages[DEPTH-1];

endmodule

//--- hdl/tracking_pkg.sv
package tracking_pkg;

   // frame coordinates
   localparam int HCOUNT_W = 11;
   localparam int VCOUNT_W = 10;

   typedef logic [HCOUNT_W-1:0] hcount_t;
   typedef logic [VCOUNT_W-1:0] vcount_t;

   // per-frame coordinate sums and in-band pixel count
   localparam int SUM_W   = 26;
   localparam int COUNT_W = 16;

   // pixel valid to mask valid, in clk_camera cycles
   localparam int CHROMA_LATENCY = 2;

   // default camera window
   localparam int DEF_FRAME_W = 320;
   localparam int DEF_FRAME_H = 180;

   // Cr = 128 + floor((112*R - 94*G - 18*B) / 256), clamped to 0..255
   localparam logic [7:0] CR_OFFSET = 8'd128;
   localparam logic [7:0] CR_KR     = 8'd112;
   localparam logic [7:0] CR_KG     = 8'd94;
   localparam logic [7:0] CR_KB     = 8'd18;

endpackage

//--- hdl/camera_pkg.sv
package camera_pkg;

   // parallel camera bus, one byte per pclk edge
   localparam int BYTE_W = 8;

   // RGB565 pixel, two bus bytes, high byte first
   localparam int PIXEL_W = 16;

   // field widths, red in the top bits and blue in the bottom bits
   localparam int RED_W   = 5;
   localparam int GREEN_W = 6;
   localparam int BLUE_W  = 5;

   // expanded channel width
   // a field is shifted left and its low bits are zero filled
   localparam int CHAN_W = 8;

   typedef logic [BYTE_W-1:0]  byte_t;
   typedef logic [PIXEL_W-1:0] pixel_t;

endpackage
